// ==== src.f ====
hw/bus_pkg.sv
hw/msg_pkg.sv
hw/session_engine.sv
hw/message_log.sv
hw/console_regs.sv
hw/sys_console.sv
bench/console_sva.sv
bench/tb_sys_console.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := tb_sys_console
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_sys_console.sv ====
module tb_sys_console import bus_pkg::*, msg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 4000;

	typedef logic [4:0][7:0] msg_t;

	logic              clk;
	logic              rst_n_i;
	logic [ADDR_W-1:0] bus_addr_i;
	logic              bus_read_i;
	logic              bus_write_i;
	logic [DATA_W-1:0] bus_wdata_i;
	logic [DATA_W-1:0] bus_rdata_o;

	int          cycles;
	int          checks;
	int          errors;
	logic [31:0] lfsr_q;

	// model of the log
	logic [7:0] model_log[$];
	logic       model_ovf;
	int         model_len;
	int         model_rd;
	logic [7:0] model_seq;
	logic [1:0] host_val;
	logic [7:0] node_val;

	// pending compares
	string      name_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] act_q[$];

	sys_console u_dut (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_addr_i  (bus_addr_i),
		.bus_read_i  (bus_read_i),
		.bus_write_i (bus_write_i),
		.bus_wdata_i (bus_wdata_i),
		.bus_rdata_o (bus_rdata_o)
	);

	bind sys_console console_sva u_sva (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_addr_i  (bus_addr_i),
		.bus_read_i  (bus_read_i),
		.bus_write_i (bus_write_i),
		.byte_wr_i   (byte_wr),
		.msg_end_i   (msg_end)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [7:0] random_bits(int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return r;
	endfunction

	function automatic msg_t expected_message(msg_op_e op, logic [1:0] host,
		logic [7:0] node, logic [7:0] seq);
		msg_t m;
		m[0] = op;
		m[1] = {6'b0, host};
		m[2] = node;
		m[3] = seq;
		m[4] = m[0] ^ m[1] ^ m[2] ^ m[3];
		return m;
	endfunction

	function automatic void model_append(msg_op_e op);
		msg_t m;
		m = expected_message(op, host_val, node_val, model_seq);
		for (int i = 0; i < MSG_LEN; i++) begin
			if (model_log.size() < LOG_DEPTH) begin
				model_log.push_back(m[i]);
			end else begin
				model_ovf = 1'b1;
			end
		end
		model_len = model_log.size();
		model_seq = model_seq + 8'd1;
	endfunction

	function automatic void model_clear();
		model_log.delete();
		model_ovf = 1'b0;
		model_len = 0;
		model_rd  = 0;
	endfunction

	// next pop with the pointer wrapping at the length
	function automatic logic [7:0] model_pop();
		logic [7:0] b;
		if (model_len == 0) begin
			return 8'h00;
		end
		b = model_log[model_rd];
		model_rd = (model_rd + 1 == model_len) ? 0 : model_rd + 1;
		return b;
	endfunction

	task automatic check_value(string name, logic [7:0] exp, logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s expected %02h actual %02h", name, exp, act);
		end
	endtask

	// compare process
	initial begin
		forever begin
			@(posedge clk);
			while (act_q.size() > 0) begin
				check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
			end
		end
	end

	task automatic bus_write(logic [ADDR_W-1:0] addr, logic [7:0] data);
		@(posedge clk);
		bus_addr_i  <= addr;
		bus_wdata_i <= data;
		bus_write_i <= 1'b1;
		@(posedge clk);
		bus_write_i <= 1'b0;
	endtask

	// read data settles one edge after the strobe and is sampled two edges later
	task automatic bus_read(logic [ADDR_W-1:0] addr, output logic [7:0] data);
		@(posedge clk);
		bus_addr_i <= addr;
		bus_read_i <= 1'b1;
		@(posedge clk);
		bus_read_i <= 1'b0;
		@(posedge clk);
		@(posedge clk);
		data = bus_rdata_o;
	endtask

	task automatic expect_read(logic [ADDR_W-1:0] addr, logic [7:0] exp, string name);
		logic [7:0] d;
		bus_read(addr, d);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(d);
	endtask

	task automatic wait_engine_idle();
		logic [7:0] s;
		do begin
			bus_read(REG_STATUS, s);
		end while (s[STATUS_BUSY_BIT]);
	endtask

	task automatic send_message(logic [7:0] cmd, msg_op_e op);
		host_val = 2'(random_bits(2));
		node_val = random_bits(8);
		bus_write(REG_HOST, {6'b0, host_val});
		bus_write(REG_NODE, node_val);
		bus_write(REG_STATUS, cmd);
		model_append(op);
		wait_engine_idle();
	endtask

	task automatic pop_and_check(int n, string name);
		for (int i = 0; i < n; i++) begin
			expect_read(REG_DATA, model_pop(), name);
		end
	endtask

	function automatic logic [7:0] model_status();
		logic [7:0] s;
		s = '0;
		s[STATUS_READY_BIT] = (model_len != 0);
		s[STATUS_OVF_BIT]   = model_ovf;
		return s;
	endfunction

	initial begin
		clk         = 1'b0;
		rst_n_i     = 1'b0;
		bus_addr_i  = '0;
		bus_read_i  = 1'b0;
		bus_write_i = 1'b0;
		bus_wdata_i = '0;
		cycles      = 0;
		checks      = 0;
		errors      = 0;
		lfsr_q      = 32'hbf19_c17e;
		model_seq   = '0;
		host_val    = '0;
		node_val    = '0;
		model_clear();
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;

		expect_read(REG_STATUS, 8'h00, "reset_status");
		expect_read(REG_LENGTH, 8'h00, "reset_length");
		expect_read(REG_DATA, 8'h00, "reset_data");

		send_message(CMD_CONNECT, MSG_CONNECT);
		expect_read(REG_STATUS, model_status(), "connect_status");
		expect_read(REG_LENGTH, 8'(model_len), "connect_length");
		pop_and_check(MSG_LEN, "connect_pop");

		send_message(CMD_CONNECTED, MSG_CONNECTED);
		expect_read(REG_LENGTH, 8'(model_len), "connected_length");
		pop_and_check(2 * MSG_LEN + 1, "connected_pop");

		// second command lands while the engine is busy
		@(posedge clk);
		bus_addr_i  <= REG_STATUS;
		bus_wdata_i <= CMD_CONNECT;
		bus_write_i <= 1'b1;
		@(posedge clk);
		bus_wdata_i <= CMD_CONNECTED;
		@(posedge clk);
		bus_write_i <= 1'b0;
		model_append(MSG_CONNECT);
		wait_engine_idle();
		expect_read(REG_LENGTH, 8'(model_len), "busy_length");

		bus_write(REG_STATUS, CMD_CLEAR);
		model_clear();
		for (int i = 0; i < 4; i++) begin
			send_message(CMD_CONNECT, MSG_CONNECT);
		end
		expect_read(REG_LENGTH, 8'(model_len), "overflow_length");
		expect_read(REG_STATUS, model_status(), "overflow_status");
		pop_and_check(LOG_DEPTH, "overflow_pop");

		bus_write(REG_STATUS, CMD_CLEAR);
		model_clear();
		expect_read(REG_STATUS, 8'h00, "clear_status");
		expect_read(REG_LENGTH, 8'h00, "clear_length");
		host_val = 2'(random_bits(2));
		node_val = random_bits(8);
		bus_write(REG_HOST, {6'b0, host_val});
		bus_write(REG_NODE, node_val);
		expect_read(REG_HOST, {6'b0, host_val}, "host_readback");
		expect_read(REG_NODE, node_val, "node_readback");

		repeat (3) @(posedge clk);
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			u_dut.u_sva.fail_count);
		if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== bench/console_sva.sv ====
module console_sva import bus_pkg::*, msg_pkg::*; (
	input logic              clk,
	input logic              rst_n_i,
	input logic [ADDR_W-1:0] bus_addr_i,
	input logic              bus_read_i,
	input logic              bus_write_i,
	input logic              byte_wr_i,
	input logic              msg_end_i
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [3:0] run_q;
	logic       data_rd;
	int         fail_count;

	assign data_rd = bus_read_i && (bus_addr_i == REG_DATA);

	// length of the current strobe run
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			run_q <= '0;
		end else if (byte_wr_i) begin
			run_q <= run_q + 4'd1;
		end else begin
			run_q <= '0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) !(bus_read_i && bus_write_i))
	else begin
		$error("bus read and write asserted together");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) data_rd |=> !data_rd)
	else begin
		$error("data reads closer than two cycles");
		fail_count++;
	end

	// end pulse rides on the last strobe of a run and nowhere else
	assert property (@(posedge clk) disable iff (!rst_n_i)
		msg_end_i == (byte_wr_i && run_q == 4'(MSG_LEN - 1)))
	else begin
		$error("message end not on the last byte strobe");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) byte_wr_i |-> run_q < 4'(MSG_LEN))
	else begin
		$error("byte strobe run too long");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		(!byte_wr_i && run_q != '0) |-> run_q == 4'(MSG_LEN))
	else begin
		$error("byte strobe run too short");
		fail_count++;
	end

endmodule

// ==== hw/sys_console.sv ====
module sys_console import bus_pkg::*, msg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] bus_addr_i,
	input  logic              bus_read_i,
	input  logic              bus_write_i,
	input  logic [DATA_W-1:0] bus_wdata_i,
	output logic [DATA_W-1:0] bus_rdata_o
);

	// regs to engine
	logic       start_connect;
	logic       start_connected;
	logic [1:0] host_addr;
	logic [7:0] node_id;

	// engine to log and regs
	logic       byte_wr;
	logic [7:0] byte_data;
	logic       msg_end;
	logic       busy;

	// regs and log
	logic             log_clear;
	logic             log_pop;
	logic [7:0]       head_byte;
	logic [LEN_W-1:0] log_len;
	logic             ready;
	logic             overflow;

	console_regs u_regs (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.bus_addr_i        (bus_addr_i),
		.bus_read_i        (bus_read_i),
		.bus_write_i       (bus_write_i),
		.bus_wdata_i       (bus_wdata_i),
		.bus_rdata_o       (bus_rdata_o),
		.busy_i            (busy),
		.ready_i           (ready),
		.overflow_i        (overflow),
		.log_len_i         (log_len),
		.head_byte_i       (head_byte),
		.start_connect_o   (start_connect),
		.start_connected_o (start_connected),
		.clear_o           (log_clear),
		.pop_o             (log_pop),
		.host_addr_o       (host_addr),
		.node_id_o         (node_id)
	);

	session_engine u_engine (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.start_connect_i   (start_connect),
		.start_connected_i (start_connected),
		.host_addr_i       (host_addr),
		.node_id_i         (node_id),
		.byte_wr_o         (byte_wr),
		.byte_data_o       (byte_data),
		.msg_end_o         (msg_end),
		.busy_o            (busy)
	);

	message_log u_log (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.byte_wr_i   (byte_wr),
		.byte_data_i (byte_data),
		.msg_end_i   (msg_end),
		.clear_i     (log_clear),
		.pop_i       (log_pop),
		.head_byte_o (head_byte),
		.log_len_o   (log_len),
		.ready_o     (ready),
		.overflow_o  (overflow)
	);

endmodule

// ==== hw/console_regs.sv ====
module console_regs import bus_pkg::*, msg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] bus_addr_i,
	input  logic              bus_read_i,
	input  logic              bus_write_i,
	input  logic [DATA_W-1:0] bus_wdata_i,
	output logic [DATA_W-1:0] bus_rdata_o,
	input  logic              busy_i,
	input  logic              ready_i,
	input  logic              overflow_i,
	input  logic [LEN_W-1:0]  log_len_i,
	input  logic [7:0]        head_byte_i,
	output logic              start_connect_o,
	output logic              start_connected_o,
	output logic              clear_o,
	output logic              pop_o,
	output logic [1:0]        host_addr_o,
	output logic [7:0]        node_id_o
);

	logic [1:0]        host_q;
	logic [7:0]        node_q;
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] rd_mux;
	logic [DATA_W-1:0] status_byte;
	logic              data_rd;
	logic              log_empty;
	logic              cmd_wr;

	assign log_empty = (log_len_i == '0);
	assign data_rd   = bus_read_i && (bus_addr_i == REG_DATA);
	assign cmd_wr    = bus_write_i && (bus_addr_i == REG_STATUS);

	// pop with the read itself
	// head byte is valid again one cycle later
	assign pop_o = data_rd && !log_empty;

	assign host_addr_o = host_q;
	assign node_id_o   = node_q;
	assign bus_rdata_o = rdata_q;

	always_comb begin
		status_byte                   = '0;
		status_byte[STATUS_BUSY_BIT]  = busy_i;
		status_byte[STATUS_READY_BIT] = ready_i;
		status_byte[STATUS_OVF_BIT]   = overflow_i;
	end

	// unmapped addresses read as zero
	always_comb begin
		case (bus_addr_i)
			REG_STATUS: rd_mux = status_byte;
			REG_DATA:   rd_mux = log_empty ? '0 : head_byte_i;
			REG_LENGTH: rd_mux = {{(DATA_W - LEN_W){1'b0}}, log_len_i};
			REG_HOST:   rd_mux = {6'b0, host_q};
			REG_NODE:   rd_mux = node_q;
			default:    rd_mux = '0;
		endcase
	end

	// command pulses one cycle after the write
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			start_connect_o   <= 1'b0;
			start_connected_o <= 1'b0;
			clear_o           <= 1'b0;
		end else begin
			start_connect_o   <= cmd_wr && (bus_wdata_i == CMD_CONNECT);
			start_connected_o <= cmd_wr && (bus_wdata_i == CMD_CONNECTED);
			clear_o           <= cmd_wr && (bus_wdata_i == CMD_CLEAR);
		end
	end

	// host and node registers and the held read data
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			host_q  <= '0;
			node_q  <= '0;
			rdata_q <= '0;
		end else begin
			if (bus_write_i && bus_addr_i == REG_HOST) begin
				host_q <= bus_wdata_i[1:0];
			end
			if (bus_write_i && bus_addr_i == REG_NODE) begin
				node_q <= bus_wdata_i;
			end
			if (bus_read_i) begin
				rdata_q <= rd_mux;
			end
		end
	end

endmodule

// ==== hw/message_log.sv ====
module message_log import msg_pkg::*; (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             byte_wr_i,
	input  logic [7:0]       byte_data_i,
	input  logic             msg_end_i,
	input  logic             clear_i,
	input  logic             pop_i,
	output logic [7:0]       head_byte_o,
	output logic [LEN_W-1:0] log_len_o,
	output logic             ready_o,
	output logic             overflow_o
);

	logic [7:0] mem [LOG_DEPTH];

	logic [LEN_W-1:0] wr_idx_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] rd_ptr_q;
	logic             ready_q;
	logic             ovf_q;
	logic [7:0]       head_q;

	logic             fits;
	logic [LEN_W-1:0] wr_idx_nxt;
	logic [LEN_W-1:0] rd_ptr_inc;

	// room left for one more byte
	assign fits = (wr_idx_q < LEN_W'(LOG_DEPTH));

	assign wr_idx_nxt = (byte_wr_i && fits) ? wr_idx_q + LEN_W'(1) : wr_idx_q;
	assign rd_ptr_inc = rd_ptr_q + LEN_W'(1);

	assign head_byte_o = head_q;
	assign log_len_o   = len_q;
	assign ready_o     = ready_q;
	assign overflow_o  = ovf_q;

	// bytes past full depth are not stored
	always_ff @(posedge clk) begin
		if (byte_wr_i && fits) begin
			mem[wr_idx_q[LOG_AW-1:0]] <= byte_data_i;
		end
	end

	// synchronous read that trails the pointer by one cycle
	always_ff @(posedge clk) begin
		head_q <= mem[rd_ptr_q[LOG_AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_idx_q <= '0;
			len_q    <= '0;
			rd_ptr_q <= '0;
			ready_q  <= 1'b0;
			ovf_q    <= 1'b0;
		end else if (clear_i) begin
			wr_idx_q <= '0;
			len_q    <= '0;
			rd_ptr_q <= '0;
			ready_q  <= 1'b0;
			ovf_q    <= 1'b0;
		end else begin
			wr_idx_q <= wr_idx_nxt;
			if (byte_wr_i && !fits) begin
				ovf_q <= 1'b1;
			end
			// length only moves on a finished message
			if (msg_end_i) begin
				len_q   <= wr_idx_nxt;
				ready_q <= 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_inc == len_q) ? '0 : rd_ptr_inc;
			end
		end
	end

endmodule

// ==== hw/session_engine.sv ====
module session_engine import msg_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       start_connect_i,
	input  logic       start_connected_i,
	input  logic [1:0] host_addr_i,
	input  logic [7:0] node_id_i,
	output logic       byte_wr_o,
	output logic [7:0] byte_data_o,
	output logic       msg_end_o,
	output logic       busy_o
);

	engine_state_e state_q;

	// index of the byte on the output in EMIT
	logic [2:0] cnt_q;
	logic       last_byte;

	// sequence number wrapping at 256
	logic [7:0] seq_q;

	// fields captured when a command is accepted
	msg_op_e    op_q;
	logic [1:0] host_q;
	logic [7:0] node_q;

	// running xor of the bytes already sent
	logic [7:0] chk_q;

	logic start;

	assign start     = start_connect_i | start_connected_i;
	assign last_byte = (cnt_q == 3'(MSG_LEN - 1));

	assign byte_wr_o = (state_q == EMIT);
	assign msg_end_o = byte_wr_o && last_byte;
	assign busy_o    = (state_q != IDLE);

	// output byte picked by the counter
	// checksum is the last byte
	always_comb begin
		case (cnt_q)
			3'd0:    byte_data_o = op_q;
			3'd1:    byte_data_o = {6'b0, host_q};
			3'd2:    byte_data_o = node_q;
			3'd3:    byte_data_o = seq_q;
			default: byte_data_o = chk_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			cnt_q   <= '0;
			seq_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					// a start while busy is lost
					if (start) begin
						state_q <= EMIT;
						cnt_q   <= '0;
					end
				end
				EMIT: begin
					if (last_byte) begin
						state_q <= DONE;
						seq_q   <= seq_q + 8'd1;
					end else begin
						cnt_q <= cnt_q + 3'd1;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// message fields and checksum
	always_ff @(posedge clk) begin
		if (state_q == IDLE && start) begin
			op_q   <= start_connect_i ? MSG_CONNECT : MSG_CONNECTED;
			host_q <= host_addr_i;
			node_q <= node_id_i;
			chk_q  <= '0;
		end else if (state_q == EMIT) begin
			chk_q <= chk_q ^ byte_data_o;
		end
	end

endmodule

// ==== hw/msg_pkg.sv ====
package msg_pkg;

	// opcode carried in the first byte of a message
	typedef enum logic [7:0] {
		MSG_CONNECT   = 8'h01,
		MSG_CONNECTED = 8'h02
	} msg_op_e;

	// session engine states
	typedef enum logic [1:0] {
		IDLE,
		EMIT,
		DONE
	} engine_state_e;

	// five bytes of opcode, host, node, sequence and checksum
	localparam int MSG_LEN = 5;

	// log storage
	localparam int LOG_DEPTH = 16;
	localparam int LOG_AW    = 4;

	// length counter must reach LOG_DEPTH itself
	localparam int LEN_W = 5;

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

	// bus widths
	localparam int ADDR_W = 3;
	localparam int DATA_W = 8;

	// register map
	localparam logic [ADDR_W-1:0] REG_STATUS = 3'd0;
	localparam logic [ADDR_W-1:0] REG_DATA   = 3'd1;
	localparam logic [ADDR_W-1:0] REG_LENGTH = 3'd2;
	localparam logic [ADDR_W-1:0] REG_HOST   = 3'd3;
	localparam logic [ADDR_W-1:0] REG_NODE   = 3'd4;

	// command bytes written to the status register
	localparam logic [DATA_W-1:0] CMD_CONNECT   = 8'hbb;
	localparam logic [DATA_W-1:0] CMD_CONNECTED = 8'hcc;
	localparam logic [DATA_W-1:0] CMD_CLEAR     = 8'hdd;

	// status byte layout
	localparam int STATUS_BUSY_BIT  = 0;
	localparam int STATUS_READY_BIT = 1;
	localparam int STATUS_OVF_BIT   = 2;

endpackage
